//--- logic/atop_macros.svh
// --------------------
// Width and depth macros of the atomic resolver
// --------------------
`ifndef ATOP_MACROS_SVH
`define ATOP_MACROS_SVH

// Data and address width
`define ATOP_DATA_W 32

// Request ID width
`define ATOP_ID_W 4

// Byte enables per word
`define ATOP_BE_W 4

// Outstanding responses held for the core
`define ATOP_RSP_DEPTH 2

`endif

//--- logic/atop_pkg.sv
// --------------------
// Atomic opcode enum and controller state enum
// Read-modify-write classification shared by RTL and model
// --------------------
package atop_pkg;

  // RISC-V AMO funct5 codes with bit 5 set, zero for plain accesses
  typedef enum logic [5:0] {
    AMO_NONE = 6'h00,
    AMO_ADD  = 6'h20,
    AMO_SWAP = 6'h21,
    AMO_LR   = 6'h22,
    AMO_SC   = 6'h23,
    AMO_XOR  = 6'h24,
    AMO_OR   = 6'h28,
    AMO_AND  = 6'h2C,
    AMO_MIN  = 6'h30,
    AMO_MAX  = 6'h34,
    AMO_MINU = 6'h38,
    AMO_MAXU = 6'h3C
  } atop_e;

  // Resolver FSM, the write-back is issued straight from the ALU
  typedef enum logic {
    IDLE,
    DO_AMO
  } amo_state_e;

  // Atomics other than LR/SC need a read and a locked write-back
  function automatic logic is_amo_rmw(atop_e op);
    return op[5] && !(op inside {AMO_LR, AMO_SC});
  endfunction

endpackage

//--- logic/amo_controller.sv
// --------------------
// Atomic FSM and memory request mux
// Forwards core requests, issues the AMO write-back
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module amo_controller (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic [`ATOP_DATA_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  atop_pkg::atop_e         atop_i,
  input  logic                    rsp_ready_i,
  input  logic                    mem_gnt_i,
  input  logic                    sc_success_i,
  input  logic [`ATOP_DATA_W-1:0] amo_result_i,
  output logic                    gnt_o,
  output logic                    mem_req_o,
  output logic [`ATOP_DATA_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`ATOP_DATA_W-1:0] mem_wdata_o,
  output logic [`ATOP_BE_W-1:0]   mem_be_o,
  output logic [`ATOP_ID_W-1:0]   mem_aid_o,
  output atop_pkg::atop_e         amo_op_o,
  output logic [`ATOP_DATA_W-1:0] amo_operand_o,
  output logic                    wb_pending_o
);
  import atop_pkg::*;

  amo_state_e              state_q, state_d;
  logic                    amo_busy;
  logic                    load_amo;
  atop_e                   op_q;
  logic [`ATOP_DATA_W-1:0] addr_q;
  logic [`ATOP_DATA_W-1:0] operand_q;
  logic                    wb_pending_q;

  // The memory port is claimed while the write-back is outstanding
  assign amo_busy = (state_q == DO_AMO);
  assign gnt_o    = rsp_ready_i & mem_gnt_i & ~amo_busy;
  assign load_amo = req_i & gnt_o & is_amo_rmw(atop_i);

  assign amo_op_o      = op_q;
  assign amo_operand_o = operand_q;
  assign wb_pending_o  = wb_pending_q;

  always_comb begin
    state_d     = state_q;
    mem_req_o   = req_i & rsp_ready_i;
    mem_addr_o  = addr_i;
    // A successful SC becomes a plain store
    mem_we_o    = we_i | (sc_success_i & (atop_i == AMO_SC));
    mem_wdata_o = wdata_i;
    mem_be_o    = be_i;
    mem_aid_o   = aid_i;
    unique case (state_q)
      IDLE: begin
        if (load_amo) begin
          state_d = DO_AMO;
        end
      end
      DO_AMO: begin
        mem_req_o   = 1'b1;
        mem_addr_o  = addr_q;
        mem_we_o    = 1'b1;
        mem_wdata_o = amo_result_i;
        mem_be_o    = {`ATOP_BE_W{1'b1}};
        if (mem_gnt_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      op_q         <= AMO_NONE;
      wb_pending_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Marks the cycle in which the write-back answer returns
      wb_pending_q <= amo_busy & mem_gnt_i;
      if (load_amo) begin
        op_q <= atop_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= addr_i;
      operand_q <= wdata_i;
    end
  end

endmodule

//--- logic/amo_alu.sv
// --------------------
// AMO ALU with loaded-word register
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module amo_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    mem_rvalid_i,
  input  logic [`ATOP_DATA_W-1:0] mem_rdata_i,
  input  atop_pkg::atop_e         amo_op_i,
  input  logic [`ATOP_DATA_W-1:0] amo_operand_i,
  output logic [`ATOP_DATA_W-1:0] amo_result_o
);
  import atop_pkg::*;

  logic [`ATOP_DATA_W-1:0] loaded_q;
  logic [`ATOP_DATA_W-1:0] loaded;
  logic [`ATOP_DATA_W:0]   add_a;
  logic [`ATOP_DATA_W:0]   add_b;
  logic [`ATOP_DATA_W:0]   add_sum;
  logic                    is_cmp;
  logic                    cmp_signed;
  logic                    lt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= '0;
    end else if (mem_rvalid_i) begin
      loaded_q <= mem_rdata_i;
    end
  end

  // Forward the old word in the cycle it arrives
  assign loaded = mem_rvalid_i ? mem_rdata_i : loaded_q;

  // --------------------
  // Shared 33-bit adder
  // --------------------
  assign is_cmp     = amo_op_i inside {AMO_MAX, AMO_MIN, AMO_MAXU, AMO_MINU};
  assign cmp_signed = amo_op_i inside {AMO_MAX, AMO_MIN};

  always_comb begin
    add_a = {cmp_signed & loaded[`ATOP_DATA_W-1], loaded};
    add_b = {cmp_signed & amo_operand_i[`ATOP_DATA_W-1], amo_operand_i};
    // Compares compute loaded - operand, carry in supplies the +1
    if (is_cmp) begin
      add_b = ~add_b;
    end
  end

  assign add_sum = add_a + add_b + {{`ATOP_DATA_W{1'b0}}, is_cmp};
  // Sign of the extended difference, loaded < operand
  assign lt      = add_sum[`ATOP_DATA_W];

  always_comb begin
    unique case (amo_op_i)
      AMO_SWAP:           amo_result_o = amo_operand_i;
      AMO_ADD:            amo_result_o = add_sum[`ATOP_DATA_W-1:0];
      AMO_AND:            amo_result_o = loaded & amo_operand_i;
      AMO_OR:             amo_result_o = loaded | amo_operand_i;
      AMO_XOR:            amo_result_o = loaded ^ amo_operand_i;
      AMO_MAX, AMO_MAXU:  amo_result_o = lt ? amo_operand_i : loaded;
      AMO_MIN, AMO_MINU:  amo_result_o = lt ? loaded : amo_operand_i;
      default:            amo_result_o = '0;
    endcase
  end

endmodule

//--- logic/lrsc_reservation.sv
// --------------------
// LR/SC reservation register
// SC success, registered SC flags for the response
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module lrsc_reservation (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    core_fire_i,
  input  logic [`ATOP_DATA_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  atop_pkg::atop_e         atop_i,
  output logic                    sc_success_d_o,
  output logic                    sc_pending_o,
  output logic                    sc_success_o
);
  import atop_pkg::*;

  logic                    res_valid_q, res_valid_d;
  logic [`ATOP_DATA_W-1:0] res_addr_q;
  logic [`ATOP_ID_W-1:0]   res_id_q;
  logic                    place;
  logic                    kill;
  logic                    sc_own;
  logic                    sc_pending_q;
  logic                    sc_success_q;

  // New LR only when free or already held by this ID, avoids live-lock
  assign place = (atop_i == AMO_LR) & (!res_valid_q | (res_id_q == aid_i));

  // Stores and RMW atomics from other IDs break the reservation
  assign kill = res_valid_q & (aid_i != res_id_q) & (addr_i == res_addr_q) &
                (we_i | is_amo_rmw(atop_i));

  assign sc_own         = res_valid_q & (atop_i == AMO_SC) & (aid_i == res_id_q);
  assign sc_success_d_o = sc_own & (addr_i == res_addr_q);

  always_comb begin
    res_valid_d = res_valid_q;
    if (core_fire_i) begin
      if (place) begin
        res_valid_d = 1'b1;
      end
      if (kill || sc_own) begin
        res_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q  <= 1'b0;
      sc_pending_q <= 1'b0;
      sc_success_q <= 1'b0;
    end else begin
      res_valid_q  <= res_valid_d;
      sc_pending_q <= core_fire_i & (atop_i == AMO_SC);
      sc_success_q <= core_fire_i & sc_success_d_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_fire_i && place) begin
      res_addr_q <= addr_i;
      res_id_q   <= aid_i;
    end
  end

  assign sc_pending_o = sc_pending_q;
  assign sc_success_o = sc_success_q;

endmodule

//--- logic/rsp_buffer.sv
// --------------------
// In-order response buffer
// ID and data queues, outstanding counter for back-pressure
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module rsp_buffer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    core_fire_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  logic                    mem_rvalid_i,
  input  logic                    wb_pending_i,
  input  logic [`ATOP_DATA_W-1:0] mem_rdata_i,
  input  logic                    mem_err_i,
  input  logic                    sc_pending_i,
  input  logic                    sc_success_i,
  input  logic                    rready_i,
  output logic                    rsp_ready_o,
  output logic                    rvalid_o,
  output logic [`ATOP_DATA_W-1:0] rdata_o,
  output logic [`ATOP_ID_W-1:0]   rid_o,
  output logic                    err_o,
  output logic                    exokay_o
);
  localparam int unsigned DEPTH = `ATOP_RSP_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  logic [`ATOP_ID_W-1:0]   id_mem   [DEPTH];
  logic [`ATOP_DATA_W-1:0] data_mem [DEPTH];
  logic                    err_mem  [DEPTH];
  logic                    ok_mem   [DEPTH];
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [PTR_W-1:0]        id_wr_q;
  logic [PTR_W-1:0]        data_wr_q;
  logic [CNT_W-1:0]        id_cnt_q;
  logic [CNT_W-1:0]        data_cnt_q;
  logic                    push_data;
  logic                    pop;
  logic [`ATOP_DATA_W-1:0] rdata_in;
  logic                    exokay_in;

  // Write-back answers never reach the core
  assign push_data = mem_rvalid_i & ~wb_pending_i;

  // SC returns 0 on success and 1 on failure
  assign rdata_in  = sc_pending_i ? {{(`ATOP_DATA_W-1){1'b0}}, ~sc_success_i} : mem_rdata_i;
  assign exokay_in = sc_pending_i & sc_success_i;

  // Both queues share the read pointer since they pop together
  assign rvalid_o    = (id_cnt_q != '0) & ((data_cnt_q != '0) | push_data);
  assign pop         = rvalid_o & rready_i;
  assign rsp_ready_o = (id_cnt_q < CNT_W'(DEPTH));
  assign rid_o       = id_mem[rd_ptr_q];

  // Empty data queue falls through
  always_comb begin
    if (data_cnt_q == '0) begin
      rdata_o  = rdata_in;
      err_o    = mem_err_i;
      exokay_o = exokay_in;
    end else begin
      rdata_o  = data_mem[rd_ptr_q];
      err_o    = err_mem[rd_ptr_q];
      exokay_o = ok_mem[rd_ptr_q];
    end
  end

  // --------------------
  // Pointers and counters
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      id_wr_q    <= '0;
      data_wr_q  <= '0;
      id_cnt_q   <= '0;
      data_cnt_q <= '0;
    end else begin
      rd_ptr_q   <= rd_ptr_q + PTR_W'(pop);
      id_wr_q    <= id_wr_q + PTR_W'(core_fire_i);
      data_wr_q  <= data_wr_q + PTR_W'(push_data);
      id_cnt_q   <= id_cnt_q + CNT_W'(core_fire_i) - CNT_W'(pop);
      data_cnt_q <= data_cnt_q + CNT_W'(push_data) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_fire_i) begin
      id_mem[id_wr_q] <= aid_i;
    end
    if (push_data) begin
      data_mem[data_wr_q] <= rdata_in;
      err_mem[data_wr_q]  <= mem_err_i;
      ok_mem[data_wr_q]   <= exokay_in;
    end
  end

endmodule

//--- logic/atop_resolver.sv
// --------------------
// Atomic resolver top level
// Controller, reservation, ALU and response buffer
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module atop_resolver (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Core side
  input  logic                    req_i,
  input  logic [`ATOP_DATA_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  atop_pkg::atop_e         atop_i,
  input  logic                    rready_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output logic [`ATOP_DATA_W-1:0] rdata_o,
  output logic [`ATOP_ID_W-1:0]   rid_o,
  output logic                    err_o,
  output logic                    exokay_o,
  // Memory side
  output logic                    mem_req_o,
  output logic [`ATOP_DATA_W-1:0] mem_addr_o,
  output logic                    mem_we_o,
  output logic [`ATOP_DATA_W-1:0] mem_wdata_o,
  output logic [`ATOP_BE_W-1:0]   mem_be_o,
  output logic [`ATOP_ID_W-1:0]   mem_aid_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [`ATOP_DATA_W-1:0] mem_rdata_i,
  input  logic                    mem_err_i
);
  import atop_pkg::*;

  logic                    core_gnt;
  logic                    core_fire;
  logic                    rsp_ready;
  logic                    sc_success_d;
  logic                    sc_pending_q;
  logic                    sc_success_q;
  logic                    wb_pending;
  atop_e                   amo_op;
  logic [`ATOP_DATA_W-1:0] amo_operand;
  logic [`ATOP_DATA_W-1:0] amo_result;

  assign gnt_o     = core_gnt;
  assign core_fire = req_i & core_gnt;

  amo_controller u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .addr_i        (addr_i),
    .we_i          (we_i),
    .wdata_i       (wdata_i),
    .be_i          (be_i),
    .aid_i         (aid_i),
    .atop_i        (atop_i),
    .rsp_ready_i   (rsp_ready),
    .mem_gnt_i     (mem_gnt_i),
    .sc_success_i  (sc_success_d),
    .amo_result_i  (amo_result),
    .gnt_o         (core_gnt),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_we_o      (mem_we_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_be_o      (mem_be_o),
    .mem_aid_o     (mem_aid_o),
    .amo_op_o      (amo_op),
    .amo_operand_o (amo_operand),
    .wb_pending_o  (wb_pending)
  );

  amo_alu u_alu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .amo_op_i      (amo_op),
    .amo_operand_i (amo_operand),
    .amo_result_o  (amo_result)
  );

  lrsc_reservation u_lrsc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_fire_i    (core_fire),
    .addr_i         (addr_i),
    .we_i           (we_i),
    .aid_i          (aid_i),
    .atop_i         (atop_i),
    .sc_success_d_o (sc_success_d),
    .sc_pending_o   (sc_pending_q),
    .sc_success_o   (sc_success_q)
  );

  rsp_buffer u_rsp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_fire_i  (core_fire),
    .aid_i        (aid_i),
    .mem_rvalid_i (mem_rvalid_i),
    .wb_pending_i (wb_pending),
    .mem_rdata_i  (mem_rdata_i),
    .mem_err_i    (mem_err_i),
    .sc_pending_i (sc_pending_q),
    .sc_success_i (sc_success_q),
    .rready_i     (rready_i),
    .rsp_ready_o  (rsp_ready),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .rid_o        (rid_o),
    .err_o        (err_o),
    .exokay_o     (exokay_o)
  );

endmodule

//--- sim/tb_clock.sv
// --------------------
// Testbench clock and reset
// --------------------
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- sim/atop_sva.sv
// --------------------
// Handshake assertions bound to the resolver
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module atop_sva (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 gnt_o,
  input  logic                 rvalid_o,
  input  logic [1:0]           rsp_cnt_i,
  input  atop_pkg::amo_state_e state_i
);
  import atop_pkg::*;

  int fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  // Buffer full blocks new grants
  no_gnt_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_cnt_i >= `ATOP_RSP_DEPTH) |-> !gnt_o)
  else begin
    fail_cnt++;
    $error("Grant while the response buffer is full");
  end

  no_gnt_in_amo: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == DO_AMO) |-> !gnt_o)
  else begin
    fail_cnt++;
    $error("Grant during the atomic write-back");
  end

  rvalid_low_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !rvalid_o)
  else begin
    fail_cnt++;
    $error("Response valid right after reset");
  end

endmodule

bind atop_resolver atop_sva sva_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .gnt_o     (gnt_o),
  .rvalid_o  (rvalid_o),
  .rsp_cnt_i (u_rsp.id_cnt_q),
  .state_i   (u_ctrl.state_q)
);

//--- sim/tb_checker.sv
// --------------------
// Response checker with shadow memory and reservation model
// Per-test report lines and error counts
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module tb_checker #(
  parameter logic [31:0] MEM_BASE = 32'h0,
  parameter logic [31:0] MEM_STEP = 32'h0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    gnt_i,
  input  logic [`ATOP_DATA_W-1:0] addr_i,
  input  logic                    we_i,
  input  logic [`ATOP_DATA_W-1:0] wdata_i,
  input  logic [`ATOP_BE_W-1:0]   be_i,
  input  logic [`ATOP_ID_W-1:0]   aid_i,
  input  atop_pkg::atop_e         atop_i,
  input  logic [`ATOP_ID_W-1:0]   mem_aid_i,
  input  logic                    rvalid_i,
  input  logic                    rready_i,
  input  logic [`ATOP_DATA_W-1:0] rdata_i,
  input  logic [`ATOP_ID_W-1:0]   rid_i,
  input  logic                    err_i,
  input  logic                    exokay_i,
  input  int                      test_idx_i,
  output int                      pending_o,
  output int                      err_cnt_o,
  output int                      chk_cnt_o
);
  import atop_pkg::*;

  logic [`ATOP_DATA_W-1:0] shadow [8];
  logic                    res_v;
  logic [`ATOP_DATA_W-1:0] res_addr;
  logic [`ATOP_ID_W-1:0]   res_id;
  logic [`ATOP_ID_W-1:0]   exp_id_q [$];
  logic [`ATOP_DATA_W-1:0] exp_data_q [$];
  logic                    exp_ok_q [$];
  int                      errs;
  int                      checks;
  int                      test_errs;
  int                      test_checks;
  int                      last_idx;
  int                      outstanding;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  function automatic string test_name(input int idx);
    case (idx)
      0: return "plain_rw";
      1: return "amo_logic";
      2: return "amo_minmax";
      3: return "lr_sc";
      default: return "backpressure";
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // New memory word for a read-modify-write atomic
  function automatic logic [31:0] combine_word(input atop_e op, input logic [31:0] old,
                                               input logic [31:0] opnd);
    case (op)
      AMO_SWAP: return opnd;
      AMO_ADD:  return old + opnd;
      AMO_AND:  return old & opnd;
      AMO_OR:   return old | opnd;
      AMO_XOR:  return old ^ opnd;
      AMO_MAX:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      AMO_MIN:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      AMO_MAXU: return (old > opnd) ? old : opnd;
      AMO_MINU: return (old < opnd) ? old : opnd;
      default:  return old;
    endcase
  endfunction

  // --------------------
  // Model update at grant
  // --------------------
  task automatic apply_request();
    logic [2:0]  idx;
    logic [31:0] old;
    logic        rmw;
    logic        sc_own;
    logic        sc_ok;
    logic        kill;
    idx    = addr_i[4:2];
    old    = shadow[idx];
    rmw    = atop_i[5] && (atop_i != AMO_LR) && (atop_i != AMO_SC);
    sc_own = res_v && (atop_i == AMO_SC) && (aid_i == res_id);
    sc_ok  = sc_own && (addr_i == res_addr);
    kill   = res_v && (aid_i != res_id) && (addr_i == res_addr) && (we_i || rmw);
    exp_id_q.push_back(aid_i);
    if (atop_i == AMO_SC) begin
      exp_data_q.push_back(sc_ok ? 32'd0 : 32'd1);
      exp_ok_q.push_back(sc_ok);
      if (sc_ok) begin
        shadow[idx] = merge_bytes(old, wdata_i, be_i);
      end
    end else if (rmw) begin
      exp_data_q.push_back(old);
      exp_ok_q.push_back(1'b0);
      shadow[idx] = combine_word(atop_i, old, wdata_i);
    end else if (we_i) begin
      exp_data_q.push_back(32'd0);
      exp_ok_q.push_back(1'b0);
      shadow[idx] = merge_bytes(old, wdata_i, be_i);
    end else begin
      exp_data_q.push_back(old);
      exp_ok_q.push_back(1'b0);
    end
    if ((atop_i == AMO_LR) && (!res_v || (aid_i == res_id))) begin
      res_v    = 1'b1;
      res_addr = addr_i;
      res_id   = aid_i;
    end
    if (kill || sc_own) begin
      res_v = 1'b0;
    end
  endtask

  task automatic compare_response();
    logic [`ATOP_ID_W-1:0]   e_id;
    logic [`ATOP_DATA_W-1:0] e_data;
    logic                    e_ok;
    if (exp_id_q.size() == 0) begin
      $display("Response with rid %h arrived while no request was outstanding", rid_i);
      errs++;
      test_errs++;
    end else begin
      e_id   = exp_id_q.pop_front();
      e_data = exp_data_q.pop_front();
      e_ok   = exp_ok_q.pop_front();
      checks++;
      test_checks++;
      if ((rid_i !== e_id) || (rdata_i !== e_data) ||
          (exokay_i !== e_ok) || (err_i !== 1'b0)) begin
        $display({"ERR %s: expected rid=%h rdata=%h exokay=%b err=0, ",
                  "actual rid=%h rdata=%h exokay=%b err=%b"},
                 test_name(test_idx_i), e_id, e_data, e_ok, rid_i, rdata_i, exokay_i, err_i);
        errs++;
        test_errs++;
      end
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 8; i++) begin
        shadow[i] = MEM_BASE ^ (MEM_STEP * 32'(i));
      end
      res_v = 1'b0;
      exp_id_q.delete();
      exp_data_q.delete();
      exp_ok_q.delete();
      errs        = 0;
      checks      = 0;
      test_errs   = 0;
      test_checks = 0;
      last_idx    = 0;
      pending_o   = 0;
    end else begin
      if (test_idx_i != last_idx) begin
        $display("Test %0d %s finished: %0d responses, %0d errors",
                 last_idx, test_name(last_idx), test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
        last_idx    = test_idx_i;
      end
      outstanding = exp_id_q.size();
      if (rvalid_i && rready_i) begin
        compare_response();
      end
      if (req_i && gnt_i) begin
        if (outstanding >= `ATOP_RSP_DEPTH) begin
          $display("Request granted while %0d responses were outstanding", outstanding);
          errs++;
          test_errs++;
        end
        // Granted core request goes out on the memory port with its ID
        if (mem_aid_i !== aid_i) begin
          $display("ERR %s: expected mem_aid=%h, actual mem_aid=%h",
                   test_name(test_idx_i), aid_i, mem_aid_i);
          errs++;
          test_errs++;
        end
        apply_request();
      end
      pending_o = exp_id_q.size();
    end
  end

endmodule

//--- sim/tb_top.sv
// --------------------
// Testbench top for the atomic resolver
// Memory model, random stimulus, test sequence, timeout
// --------------------
`timescale 1ns/1ps
`include "atop_macros.svh"

module tb_top;
  import atop_pkg::*;

  localparam int N_TESTS    = 5;
  localparam int N_REQS     = 200;
  localparam int MAX_CYCLES = N_TESTS * N_REQS * 8;
  localparam logic [31:0] MEM_BASE = 32'h5a00_0000;
  localparam logic [31:0] MEM_STEP = 32'h0104_1041;

  logic                    clk;
  logic                    rst_n;
  logic                    req;
  logic [`ATOP_DATA_W-1:0] addr;
  logic                    we;
  logic [`ATOP_DATA_W-1:0] wdata;
  logic [`ATOP_BE_W-1:0]   be;
  logic [`ATOP_ID_W-1:0]   aid;
  atop_e                   atop;
  logic                    rready;
  logic                    gnt;
  logic                    rvalid;
  logic [`ATOP_DATA_W-1:0] rdata;
  logic [`ATOP_ID_W-1:0]   rid;
  logic                    err;
  logic                    exokay;
  logic                    mem_req;
  logic [`ATOP_DATA_W-1:0] mem_addr;
  logic                    mem_we;
  logic [`ATOP_DATA_W-1:0] mem_wdata;
  logic [`ATOP_BE_W-1:0]   mem_be;
  logic [`ATOP_ID_W-1:0]   mem_aid;
  logic                    mem_gnt;
  logic                    mem_rvalid;
  logic [`ATOP_DATA_W-1:0] mem_rdata;
  logic                    mem_err;

  logic [`ATOP_DATA_W-1:0] mem [8];
  logic                    ans_valid_q;
  logic [`ATOP_DATA_W-1:0] ans_data_q;
  integer                  seed;
  int                      test_idx;
  int                      cycles;
  int                      pending;
  int                      chk_errs;
  int                      chk_count;
  int                      total_errs;

  tb_clock clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  atop_resolver dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .addr_i       (addr),
    .we_i         (we),
    .wdata_i      (wdata),
    .be_i         (be),
    .aid_i        (aid),
    .atop_i       (atop),
    .rready_i     (rready),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .rid_o        (rid),
    .err_o        (err),
    .exokay_o     (exokay),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .mem_aid_o    (mem_aid),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .mem_err_i    (mem_err)
  );

  tb_checker #(
    .MEM_BASE (MEM_BASE),
    .MEM_STEP (MEM_STEP)
  ) checker_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_i      (req),
    .gnt_i      (gnt),
    .addr_i     (addr),
    .we_i       (we),
    .wdata_i    (wdata),
    .be_i       (be),
    .aid_i      (aid),
    .atop_i     (atop),
    .mem_aid_i  (mem_aid),
    .rvalid_i   (rvalid),
    .rready_i   (rready),
    .rdata_i    (rdata),
    .rid_i      (rid),
    .err_i      (err),
    .exokay_i   (exokay),
    .test_idx_i (test_idx),
    .pending_o  (pending),
    .err_cnt_o  (chk_errs),
    .chk_cnt_o  (chk_count)
  );

  // --------------------
  // Memory model
  // --------------------
  // Access at grant, answer one cycle later; writes answer 0
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ans_valid_q <= 1'b0;
      ans_data_q  <= '0;
      for (int i = 0; i < 8; i++) begin
        mem[i] <= MEM_BASE ^ (MEM_STEP * 32'(i));
      end
    end else begin
      ans_valid_q <= mem_req && mem_gnt;
      ans_data_q  <= '0;
      if (mem_req && mem_gnt) begin
        if (mem_we) begin
          for (int b = 0; b < `ATOP_BE_W; b++) begin
            if (mem_be[b]) begin
              mem[mem_addr[4:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
          end
        end else begin
          ans_data_q <= mem[mem_addr[4:2]];
        end
      end
    end
  end

  // Random memory grant and core ready, answers presented on the falling edge
  always @(negedge clk) begin
    mem_gnt    = ($random(seed) & 3) != 0;
    rready     = (test_idx == 4) ? (($random(seed) & 1) != 0) : 1'b1;
    mem_rvalid = ans_valid_q;
    mem_rdata  = ans_data_q;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  function automatic atop_e pick_op(input int t, input int unsigned r);
    atop_e op;
    op = AMO_NONE;
    case (t)
      1: begin
        case (r % 6)
          0: op = AMO_SWAP;
          1: op = AMO_ADD;
          2: op = AMO_AND;
          3: op = AMO_OR;
          4: op = AMO_XOR;
          default: op = AMO_NONE;
        endcase
      end
      2: begin
        case (r % 5)
          0: op = AMO_MAX;
          1: op = AMO_MIN;
          2: op = AMO_MAXU;
          3: op = AMO_MINU;
          default: op = AMO_NONE;
        endcase
      end
      3: begin
        if (r % 8 < 3) begin
          op = AMO_LR;
        end else if (r % 8 < 6) begin
          op = AMO_SC;
        end
      end
      4: begin
        case (r % 12)
          0: op = AMO_SWAP;
          1: op = AMO_ADD;
          2: op = AMO_AND;
          3: op = AMO_OR;
          4: op = AMO_XOR;
          5: op = AMO_MAX;
          6: op = AMO_MIN;
          7: op = AMO_MAXU;
          8: op = AMO_MINU;
          9: op = AMO_LR;
          10: op = AMO_SC;
          default: op = AMO_NONE;
        endcase
      end
      default: op = AMO_NONE;
    endcase
    return op;
  endfunction

  // Fields are drawn on the rising edge and driven on the next falling edge
  task automatic issue_requests(input int t);
    int                    n;
    int unsigned           r;
    logic                  idle;
    atop_e                 op;
    logic                  nxt_we;
    logic [2:0]            nxt_idx;
    logic [`ATOP_ID_W-1:0] nxt_id;
    logic [31:0]           nxt_data;
    logic [3:0]            nxt_be;
    n = 0;
    @(posedge clk);
    while (n < N_REQS) begin
      idle     = ($random(seed) & 3) == 0;
      r        = $unsigned($random(seed));
      op       = pick_op(t, r);
      nxt_we   = (op == AMO_NONE) && ((t == 3) ? (r % 8 == 6) : r[31]);
      // LR/SC test stays on two words so reservations collide
      nxt_idx  = (t == 3) ? 3'($random(seed) & 1) : 3'($random(seed) & 7);
      nxt_id   = `ATOP_ID_W'($random(seed) & 3);
      nxt_data = $random(seed);
      nxt_be   = nxt_we ? 4'($random(seed) & 15) : 4'hf;
      @(negedge clk);
      if (idle) begin
        req = 1'b0;
        @(posedge clk);
      end else begin
        req   = 1'b1;
        atop  = op;
        we    = nxt_we;
        addr  = 32'(nxt_idx) << 2;
        aid   = nxt_id;
        wdata = nxt_data;
        be    = nxt_be;
        @(posedge clk);
        while (!gnt) begin
          @(posedge clk);
        end
        n++;
      end
    end
    @(negedge clk);
    req  = 1'b0;
    we   = 1'b0;
    atop = AMO_NONE;
  endtask

  task automatic drain_responses();
    while (pending != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    seed     = 32'heb5c_7c88;
    cycles   = 0;
    test_idx = 0;
    req      = 1'b0;
    addr     = '0;
    we       = 1'b0;
    wdata    = '0;
    be       = '0;
    aid      = '0;
    atop     = AMO_NONE;
    rready   = 1'b1;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    mem_err    = 1'b0;
    @(posedge rst_n);
    for (int t = 0; t < N_TESTS; t++) begin
      issue_requests(t);
      drain_responses();
      @(negedge clk);
      test_idx = t + 1;
    end
    @(posedge clk);
    @(negedge clk);
    total_errs = chk_errs + dut_i.sva_i.fail_cnt;
    $display("Summary: %0d responses checked, %0d mismatches, %0d assertion failures",
             chk_count, chk_errs, dut_i.sva_i.fail_cnt);
    if (total_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+logic
logic/atop_pkg.sv
logic/amo_controller.sv
logic/amo_alu.sv
logic/lrsc_reservation.sv
logic/rsp_buffer.sv
logic/atop_resolver.sv
sim/tb_clock.sv
sim/atop_sva.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Bender.yml
package:
  name: atop_resolver

export_include_dirs:
  - logic

sources:
  - logic/atop_pkg.sv
  - logic/amo_controller.sv
  - logic/amo_alu.sv
  - logic/lrsc_reservation.sv
  - logic/rsp_buffer.sv
  - logic/atop_resolver.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/atop_sva.sv
      - sim/tb_checker.sv
      - sim/tb_top.sv
